// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module preif_tb -f vlog.f -Mdir obj_dir
	./obj_dir/Vpreif_tb +verilator+error+limit+100 | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: rtl/fetch_req_gen.sv
// instruction-cache request fields, request valid and fetch exception vector
`timescale 1ns/1ps

module fetch_req_gen (
    input  preif_pkg::vaddr_t      pc,
    input  preif_pkg::vaddr_t      mem_alu_out,
    input  preif_pkg::paddr_t      paddr,
    input  logic                   cached,
    input  logic                   hit,
    input  logic                   fetch_enable,
    input  logic                   mem_icache_op,
    input  preif_pkg::tlb_fault_t  fault,
    output logic [19:0]            ireq_tag,
    output logic [11:0]            ireq_index_offset,
    output logic                   ireq_cached,
    output logic                   ireq_valid,
    output preif_pkg::except_vec_t fetch_except
);

    logic word_aligned;
    logic no_fault;

    assign word_aligned = (pc[1:0] == 2'b00);
    assign no_fault     = (fault == preif_pkg::FAULT_NONE);

    assign ireq_tag    = paddr[31:12];
    assign ireq_cached = cached;

    // cache op in MEM takes the index port for its maintenance address
    assign ireq_index_offset = mem_icache_op ? mem_alu_out[11:0] : pc[11:0];

    assign ireq_valid = fetch_enable && hit && no_fault && word_aligned && !mem_icache_op;

    always_comb begin
        fetch_except = '0;
        case (fault)
            preif_pkg::FAULT_REFILL:  fetch_except[preif_pkg::FETCH_TLB_REFILL_BIT] = 1'b1;
            preif_pkg::FAULT_INVALID: fetch_except[preif_pkg::FETCH_TLB_INVALID_BIT] = 1'b1;
            default:                  fetch_except = '0;
        endcase
    end

endmodule

// File: rtl/itlb_buffer.sv
// one-entry instruction TLB buffer with refill, flush, segment decode and fault detection
`timescale 1ns/1ps

module itlb_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tlb_flush,
    input  preif_pkg::vaddr_t      pc,
    input  logic                   tlb_found,
    input  preif_pkg::pfn_t        tlb_pfn0,
    input  preif_pkg::cache_attr_t tlb_c0,
    input  logic                   tlb_v0,
    input  preif_pkg::pfn_t        tlb_pfn1,
    input  preif_pkg::cache_attr_t tlb_c1,
    input  logic                   tlb_v1,
    input  preif_pkg::cache_attr_t config_k0,
    output preif_pkg::vpn2_t       lookup_vpn2,
    output preif_pkg::paddr_t      paddr,
    output logic                   cached,
    output logic                   hit,
    output logic                   tlb_stall,
    output preif_pkg::tlb_fault_t  fault
);

    preif_pkg::buf_state_t  state;

    // buffered copy of the last joint TLB answer
    preif_pkg::vpn2_t       buf_vpn2;
    logic                   buf_found;
    preif_pkg::pfn_t        buf_pfn0;
    preif_pkg::cache_attr_t buf_c0;
    logic                   buf_v0;
    preif_pkg::pfn_t        buf_pfn1;
    preif_pkg::cache_attr_t buf_c1;
    logic                   buf_v1;

    logic                   in_kseg0;
    logic                   in_kseg1;
    logic                   unmapped;
    logic                   buf_match;
    preif_pkg::pfn_t        sel_pfn;
    preif_pkg::cache_attr_t sel_c;
    logic                   sel_v;

    assign in_kseg0  = (pc[31:29] == preif_pkg::KSEG0_TOP);
    assign in_kseg1  = (pc[31:29] == preif_pkg::KSEG1_TOP);
    assign unmapped  = in_kseg0 | in_kseg1;
    assign buf_match = (state == preif_pkg::BUF_FILLED) && (buf_vpn2 == pc[31:13]);

    assign lookup_vpn2 = pc[31:13];
    assign tlb_stall   = ~unmapped & ~buf_match;   // wait one cycle for the refill
    assign hit         = unmapped | buf_match;

    // pc[12] picks the odd page of the pair
    assign sel_pfn = pc[12] ? buf_pfn1 : buf_pfn0;
    assign sel_c   = pc[12] ? buf_c1 : buf_c0;
    assign sel_v   = pc[12] ? buf_v1 : buf_v0;

    always_comb begin
        fault = preif_pkg::FAULT_NONE;
        if (unmapped) begin
            paddr  = {3'b000, pc[28:0]};
            cached = in_kseg0 && (config_k0 == preif_pkg::C_CACHEABLE);   // kseg1 never
        end else begin
            paddr  = {sel_pfn, pc[11:0]};
            cached = (sel_c == preif_pkg::C_CACHEABLE);
            if (buf_match) begin
                if (!buf_found) begin
                    fault = preif_pkg::FAULT_REFILL;
                end else if (!sel_v) begin
                    fault = preif_pkg::FAULT_INVALID;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= preif_pkg::BUF_EMPTY;
        end else if (tlb_flush) begin
            state <= preif_pkg::BUF_EMPTY;   // flush wins over a pending refill
        end else if (tlb_stall) begin
            state <= preif_pkg::BUF_FILLED;
        end
    end

    // refill payload, captured on every miss cycle
    always_ff @(posedge clk) begin
        if (tlb_stall) begin
            buf_vpn2  <= pc[31:13];
            buf_found <= tlb_found;
            buf_pfn0  <= tlb_pfn0;
            buf_c0    <= tlb_c0;
            buf_v0    <= tlb_v0;
            buf_pfn1  <= tlb_pfn1;
            buf_c1    <= tlb_c1;
            buf_v1    <= tlb_v1;
        end
    end

endmodule

// File: rtl/pc_gen.sv
// program counter register and prioritized next-PC selection
`timescale 1ns/1ps

module pc_gen #(
    parameter preif_pkg::vaddr_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pc_wr,
    input  preif_pkg::entry_sel_t entry_sel,
    input  preif_pkg::vaddr_t     epc,
    input  preif_pkg::vaddr_t     exception_vector,
    input  preif_pkg::vaddr_t     refetch_pc,
    input  logic                  prediction_failed,
    input  preif_pkg::vaddr_t     correction_vector,
    input  logic                  bpu_valid,
    input  preif_pkg::vaddr_t     bpu_target,
    output preif_pkg::vaddr_t     pc
);

    preif_pkg::vaddr_t next_pc;
    preif_pkg::vaddr_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;

    // exception unit first, then the EXE correction, then the predictor
    always_comb begin
        next_pc = pc_plus4;
        if (entry_sel != preif_pkg::ENTRY_NONE) begin
            case (entry_sel)
                preif_pkg::ENTRY_ERET:      next_pc = epc;
                preif_pkg::ENTRY_EXCEPTION: next_pc = exception_vector;
                default:                    next_pc = refetch_pc;
            endcase
        end else if (prediction_failed) begin
            next_pc = correction_vector;   // mispredict fix from EXE
        end else if (bpu_valid) begin
            next_pc = bpu_target;
        end
    end

    // holds while the hazard unit keeps pc_wr low
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (pc_wr) begin
            pc <= next_pc;
        end
    end

endmodule

// File: rtl/preif_pkg.sv
// address, VPN, PFN and exception-vector types with segment and exception constants
package preif_pkg;

    typedef logic [31:0] vaddr_t;      // virtual address
    typedef logic [31:0] paddr_t;      // physical address
    typedef logic [18:0] vpn2_t;       // va[31:13], one even/odd page pair
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cache_attr_t; // MIPS C field
    typedef logic [18:0] except_vec_t; // one-hot, as used by the pipeline

    // C field value for cacheable noncoherent
    localparam cache_attr_t C_CACHEABLE = 3'd3;

    localparam int FETCH_TLB_REFILL_BIT  = 8;
    localparam int FETCH_TLB_INVALID_BIT = 7;

    // va[31:29] of the unmapped kernel segments
    localparam logic [2:0] KSEG0_TOP = 3'b100;
    localparam logic [2:0] KSEG1_TOP = 3'b101;

    typedef enum logic [1:0] {
        FAULT_NONE,
        FAULT_REFILL,   // no matching joint TLB entry
        FAULT_INVALID   // entry found but V low
    } tlb_fault_t;

    // exception unit entry select, encoding order gives the pick order
    typedef enum logic [1:0] {
        ENTRY_NONE,
        ENTRY_ERET,
        ENTRY_EXCEPTION,
        ENTRY_REFETCH
    } entry_sel_t;

    typedef enum logic {
        BUF_EMPTY,
        BUF_FILLED
    } buf_state_t;

endpackage

// File: rtl/preif_top.sv
// pre-IF stage top level with PC generation, instruction TLB buffer and fetch request
`timescale 1ns/1ps

module preif_top #(
    parameter preif_pkg::vaddr_t RESET_PC = 32'hbfc0_0000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pc_wr,
    input  preif_pkg::entry_sel_t  entry_sel,
    input  preif_pkg::vaddr_t      epc,
    input  preif_pkg::vaddr_t      exception_vector,
    input  preif_pkg::vaddr_t      refetch_pc,
    input  logic                   prediction_failed,
    input  preif_pkg::vaddr_t      correction_vector,
    input  logic                   bpu_valid,
    input  preif_pkg::vaddr_t      bpu_target,
    input  logic                   tlb_flush,
    input  logic                   tlb_found,
    input  preif_pkg::pfn_t        tlb_pfn0,
    input  preif_pkg::cache_attr_t tlb_c0,
    input  logic                   tlb_v0,
    input  preif_pkg::pfn_t        tlb_pfn1,
    input  preif_pkg::cache_attr_t tlb_c1,
    input  logic                   tlb_v1,
    input  preif_pkg::cache_attr_t config_k0,
    input  logic                   fetch_enable,
    input  logic                   mem_icache_op,
    input  preif_pkg::vaddr_t      mem_alu_out,
    output preif_pkg::vaddr_t      pc,
    output preif_pkg::vpn2_t       lookup_vpn2,
    output logic                   tlb_stall,
    output logic [19:0]            ireq_tag,
    output logic [11:0]            ireq_index_offset,
    output logic                   ireq_cached,
    output logic                   ireq_valid,
    output preif_pkg::except_vec_t fetch_except
);

    preif_pkg::paddr_t     paddr;
    logic                  cached;
    logic                  hit;
    preif_pkg::tlb_fault_t fault;

    pc_gen #(
        .RESET_PC          (RESET_PC)
    ) i_pc_gen (
        .clk               (clk),
        .reset             (reset),
        .pc_wr             (pc_wr),
        .entry_sel         (entry_sel),
        .epc               (epc),
        .exception_vector  (exception_vector),
        .refetch_pc        (refetch_pc),
        .prediction_failed (prediction_failed),
        .correction_vector (correction_vector),
        .bpu_valid         (bpu_valid),
        .bpu_target        (bpu_target),
        .pc                (pc)
    );

    // lookup_vpn2 goes out to the joint TLB, answer comes back same cycle
    itlb_buffer i_itlb_buffer (
        .clk               (clk),
        .reset             (reset),
        .tlb_flush         (tlb_flush),
        .pc                (pc),
        .tlb_found         (tlb_found),
        .tlb_pfn0          (tlb_pfn0),
        .tlb_c0            (tlb_c0),
        .tlb_v0            (tlb_v0),
        .tlb_pfn1          (tlb_pfn1),
        .tlb_c1            (tlb_c1),
        .tlb_v1            (tlb_v1),
        .config_k0         (config_k0),
        .lookup_vpn2       (lookup_vpn2),
        .paddr             (paddr),
        .cached            (cached),
        .hit               (hit),
        .tlb_stall         (tlb_stall),
        .fault             (fault)
    );

    fetch_req_gen i_fetch_req_gen (
        .pc                (pc),
        .mem_alu_out       (mem_alu_out),
        .paddr             (paddr),
        .cached            (cached),
        .hit               (hit),
        .fetch_enable      (fetch_enable),
        .mem_icache_op     (mem_icache_op),
        .fault             (fault),
        .ireq_tag          (ireq_tag),
        .ireq_index_offset (ireq_index_offset),
        .ireq_cached       (ireq_cached),
        .ireq_valid        (ireq_valid),
        .fetch_except      (fetch_except)
    );

endmodule

// File: verification/preif_sva.sv
// concurrent checks of translation, stall, request and fetch exception rules of the pre-IF stage
`timescale 1ns/1ps

module preif_sva (
    input logic                   clk,
    input logic                   reset,
    input preif_pkg::vaddr_t      pc,
    input logic                   tlb_stall,
    input logic [19:0]            ireq_tag,
    input logic                   ireq_valid,
    input logic                   mem_icache_op,
    input preif_pkg::tlb_fault_t  fault,
    input preif_pkg::except_vec_t fetch_except
);

    int   fail_count = 0;
    logic unmapped;

    assign unmapped = (pc[31:29] == preif_pkg::KSEG0_TOP) || (pc[31:29] == preif_pkg::KSEG1_TOP);

    // kseg0 and kseg1 bypass the buffer and never stall
    kseg_translation: assert property (@(posedge clk) disable iff (reset)
        unmapped |-> (ireq_tag == {3'b000, pc[28:12]} && !tlb_stall))
        else begin
            $error("unmapped pc %h gave tag %h stall %b", pc, ireq_tag, tlb_stall);
            fail_count = fail_count + 1;
        end

    valid_needs_alignment: assert property (@(posedge clk) disable iff (reset)
        ireq_valid |-> (pc[1:0] == 2'b00 && !mem_icache_op))
        else begin
            $error("request valid at pc %h with cache op %b", pc, mem_icache_op);
            fail_count = fail_count + 1;
        end

    stall_blocks_valid: assert property (@(posedge clk) disable iff (reset)
        tlb_stall |-> !ireq_valid)
        else begin
            $error("request valid during a buffer miss at pc %h", pc);
            fail_count = fail_count + 1;
        end

    except_matches_fault: assert property (@(posedge clk) disable iff (reset)
        fetch_except[preif_pkg::FETCH_TLB_REFILL_BIT] == (fault == preif_pkg::FAULT_REFILL)
        && fetch_except[preif_pkg::FETCH_TLB_INVALID_BIT] == (fault == preif_pkg::FAULT_INVALID)
        && $countones(fetch_except) <= 1)
        else begin
            $error("fetch exception %h does not match fault %0d", fetch_except, fault);
            fail_count = fail_count + 1;
        end

endmodule

bind preif_top preif_sva i_preif_sva (
    .clk           (clk),
    .reset         (reset),
    .pc            (pc),
    .tlb_stall     (tlb_stall),
    .ireq_tag      (ireq_tag),
    .ireq_valid    (ireq_valid),
    .mem_icache_op (mem_icache_op),
    .fault         (fault),
    .fetch_except  (fetch_except)
);

// File: verification/preif_tb.sv
// testbench with clock, reset, joint TLB model, hazard model, directed tests and timeout
`timescale 1ns/1ps

module preif_tb;

    localparam preif_pkg::vaddr_t RESET_PC = 32'hbfc0_0000;
    localparam int MAX_CYCLES = 2000;   // directed tests need well under 100 cycles

    logic                   clk, reset, pc_wr, tlb_flush;
    preif_pkg::entry_sel_t  entry_sel;
    preif_pkg::vaddr_t      epc, exception_vector, refetch_pc, correction_vector, bpu_target;
    logic                   prediction_failed, bpu_valid, fetch_enable, mem_icache_op;
    preif_pkg::vaddr_t      mem_alu_out, pc;
    logic                   tlb_found, tlb_v0, tlb_v1;
    preif_pkg::pfn_t        tlb_pfn0, tlb_pfn1;
    preif_pkg::cache_attr_t tlb_c0, tlb_c1, config_k0;
    preif_pkg::vpn2_t       lookup_vpn2;
    logic                   tlb_stall, ireq_cached, ireq_valid;
    logic [19:0]            ireq_tag;
    logic [11:0]            ireq_index_offset;
    preif_pkg::except_vec_t fetch_except;

    // joint TLB contents, keyed by VPN2
    preif_pkg::vpn2_t       tab_vpn2 [8];
    preif_pkg::pfn_t        tab_pfn0 [8];
    preif_pkg::pfn_t        tab_pfn1 [8];
    preif_pkg::cache_attr_t tab_c0 [8];
    preif_pkg::cache_attr_t tab_c1 [8];
    logic                   tab_v0 [8];
    logic                   tab_v1 [8];
    int                     model_hit;
    logic [2:0]             model_sel;

    int                errors, test_errors, tests_failed, cycles, stalls;
    integer            seed;
    logic [31:0]       r;
    preif_pkg::vaddr_t old_pc, expected;

    preif_top #(.RESET_PC(RESET_PC)) i_preif_top (.*);

    assign pc_wr = ~tlb_stall;   // hazard unit holds the PC on a buffer miss

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int model_index(input preif_pkg::vpn2_t vpn2);
        int found;
        found = -1;
        for (int i = 0; i < 8; i++) begin
            if (tab_vpn2[i] == vpn2) found = i;
        end
        return found;
    endfunction

    // answer comes back in the same cycle as the lookup
    always_comb begin
        model_hit = model_index(lookup_vpn2);
        model_sel = model_hit[2:0];
        tlb_found = (model_hit >= 0);
        tlb_pfn0  = tab_pfn0[model_sel];
        tlb_c0    = tab_c0[model_sel];
        tlb_v0    = tab_v0[model_sel];
        tlb_pfn1  = tab_pfn1[model_sel];
        tlb_c1    = tab_c1[model_sel];
        tlb_v1    = tab_v1[model_sel];
    end

    function automatic preif_pkg::vaddr_t random_kseg1();
        logic [31:0] v;
        v = $random(seed);
        return {3'b101, v[28:2], 2'b00};
    endfunction

    function automatic int total_errors();
        return errors + i_preif_top.i_preif_sva.fail_count;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check(input bit ok, input string what);
        assert (ok) else begin
            $display("error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-18s %s", name, (total_errors() == test_errors) ? "ok" : "failed");
        if (total_errors() != test_errors) tests_failed++;
        test_errors = total_errors();
    endtask

    task automatic jump(input preif_pkg::vaddr_t target);
        bpu_valid  = 1'b1;
        bpu_target = target;
        step();
        bpu_valid = 1'b0;
    endtask

    task automatic count_stalls();
        stalls = 0;
        while (tlb_stall) begin
            stalls++;
            step();
        end
    endtask

    initial begin
        seed = 50;
        errors = 0;
        test_errors = 0;
        tests_failed = 0;
        reset = 1'b1;
        tlb_flush = 1'b0;
        entry_sel = preif_pkg::ENTRY_NONE;
        epc = '0;
        exception_vector = '0;
        refetch_pc = '0;
        correction_vector = '0;
        bpu_target = '0;
        prediction_failed = 1'b0;
        bpu_valid = 1'b0;
        config_k0 = 3'd3;
        fetch_enable = 1'b1;
        mem_icache_op = 1'b0;
        mem_alu_out = '0;
        for (int i = 0; i < 8; i++) begin   // pairs from va 0x0040_0000 upward
            tab_vpn2[i] = 19'h00200 + 19'(i);
            tab_pfn0[i] = 20'h01000 + 20'(2 * i);
            tab_pfn1[i] = 20'h01000 + 20'(2 * i + 1);
            tab_c0[i]   = 3'd3;
            tab_c1[i]   = 3'(i);
            tab_v0[i]   = (i != 1);   // entry 1 has an invalid even page
            tab_v1[i]   = (i != 6);
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        check(pc == RESET_PC && !tlb_stall && fetch_except == '0, "bad state after reset");
        for (int i = 0; i < 4; i++) begin
            old_pc = pc;
            step();
            check(pc == old_pc + 32'd4 && ireq_valid, $sformatf("pc %h after %h", pc, old_pc));
            check(ireq_tag == {3'b000, pc[28:12]} && !ireq_cached,
                  $sformatf("kseg1 tag %h cached %b", ireq_tag, ireq_cached));
        end
        jump(32'h8000_1000);
        check(pc == 32'h8000_1000 && ireq_tag == 20'h00001 && ireq_cached,
              $sformatf("kseg0 tag %h cached %b", ireq_tag, ireq_cached));
        config_k0 = 3'd2;
        step();
        check(ireq_tag == {3'b000, pc[28:12]} && !ireq_cached, "kseg0 cached with K0 of 2");
        config_k0 = 3'd3;
        end_test("sequential fetch");

        for (int i = 0; i < 16; i++) begin
            old_pc = pc;
            epc = random_kseg1();
            exception_vector = random_kseg1();
            refetch_pc = random_kseg1();
            correction_vector = random_kseg1();
            bpu_target = random_kseg1();
            r = $random(seed);
            entry_sel = preif_pkg::entry_sel_t'(r[1:0]);
            prediction_failed = r[2];
            bpu_valid = r[3];
            case (entry_sel)
                preif_pkg::ENTRY_ERET:      expected = epc;
                preif_pkg::ENTRY_EXCEPTION: expected = exception_vector;
                preif_pkg::ENTRY_REFETCH:   expected = refetch_pc;
                default: expected = r[2] ? correction_vector : r[3] ? bpu_target : old_pc + 32'd4;
            endcase
            step();
            check(pc == expected, $sformatf("next pc %h, expected %h", pc, expected));
        end
        entry_sel = preif_pkg::ENTRY_NONE;
        prediction_failed = 1'b0;
        bpu_valid = 1'b0;
        end_test("redirect priority");

        jump(32'h0040_0000);
        check(tlb_stall && lookup_vpn2 == 19'h00200 && !ireq_valid,
              $sformatf("mapped miss stall %b vpn2 %h", tlb_stall, lookup_vpn2));
        count_stalls();
        check(stalls == 1, "buffer miss did not take exactly one stall cycle");
        check(ireq_valid && ireq_tag == tab_pfn0[0] && ireq_cached, $sformatf("tag %h", ireq_tag));
        step();
        check(!tlb_stall && pc == 32'h0040_0004 && ireq_valid, "stall inside the buffered pair");
        jump(32'h0040_1008);   // odd page of the same pair
        check(!tlb_stall && ireq_valid && ireq_tag == tab_pfn1[0]
              && ireq_cached == (tab_c1[0] == 3'd3), $sformatf("odd page tag %h", ireq_tag));
        tlb_flush = 1'b1;
        step();
        tlb_flush = 1'b0;
        check(tlb_stall, "flush did not force a new lookup");
        count_stalls();
        check(stalls == 1 && ireq_valid && ireq_tag == tab_pfn1[0], "refill after flush wrong");
        end_test("mapped fetch");

        jump(32'h1000_0000);   // no joint TLB entry
        count_stalls();
        check(stalls == 1 && fetch_except[preif_pkg::FETCH_TLB_REFILL_BIT] && !ireq_valid,
              $sformatf("refill case except %h", fetch_except));
        jump(32'h0040_2000);
        count_stalls();
        check(stalls == 1 && fetch_except[preif_pkg::FETCH_TLB_INVALID_BIT] && !ireq_valid,
              $sformatf("invalid case except %h", fetch_except));
        end_test("tlb faults");

        prediction_failed = 1'b1;
        correction_vector = 32'hbfc0_0102;
        step();
        prediction_failed = 1'b0;
        check(pc == 32'hbfc0_0102 && !ireq_valid, "misaligned pc gave a valid request");
        jump(32'hbfc0_0200);
        fetch_enable = 1'b0;
        step();
        check(!ireq_valid, "request valid with fetch disabled");
        fetch_enable = 1'b1;
        mem_icache_op = 1'b1;
        mem_alu_out = $random(seed);
        step();
        check(!ireq_valid && ireq_index_offset == mem_alu_out[11:0],
              $sformatf("cache op index %h, expected %h", ireq_index_offset, mem_alu_out[11:0]));
        mem_icache_op = 1'b0;
        step();
        check(ireq_valid && ireq_index_offset == pc[11:0], "request not restored after cache op");
        end_test("request gating");

        $display("tests run 5, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests_failed, errors, i_preif_top.i_preif_sva.fail_count);
        if (total_errors() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: vlog.f
rtl/preif_pkg.sv
rtl/pc_gen.sv
rtl/itlb_buffer.sv
rtl/fetch_req_gen.sv
rtl/preif_top.sv
verification/preif_sva.sv
verification/preif_tb.sv
